/* Bender.yml */
package:
  name: bpred

sources:
  - include_dirs:
      - .
    files:
      - bpred_pkg.sv
      - bpred_btb.sv
      - bpred_pht.sv
      - bpred_lookup.sv
      - bpred_track.sv
      - bpred_resolve.sv
      - bpred_top.sv
      - target: test
        files:
          - bpred_tb.sv

/* bpred.f */
+incdir+.
bpred_pkg.sv
bpred_btb.sv
bpred_pht.sv
bpred_lookup.sv
bpred_track.sv
bpred_resolve.sv
bpred_top.sv
bpred_tb.sv

/* bpred_btb.sv */
// direct-mapped tagged branch target buffer with a write-first read port.
`timescale 1ns/1ps
`default_nettype none

`include "bpred_settings.svh"

module bpred_btb (
    input  logic                clk,
    input  logic                reset_i,
    input  bpred_pkg::btb_idx_t rd_idx_i,
    input  bpred_pkg::addr_t    rd_tag_i,
    output logic                hit_o,
    output bpred_pkg::addr_t    target_o,
    output logic                is_jump_o,
    output logic                is_branch_o,
    input  logic                we_i,
    input  bpred_pkg::btb_idx_t wr_idx_i,
    input  bpred_pkg::addr_t    wr_tag_i,
    input  bpred_pkg::addr_t    wr_target_i,
    input  logic                wr_is_jump_i,
    input  logic                wr_is_branch_i
);

    localparam int AW = $bits(rd_tag_i);

    logic [AW-1:0] tag_q    [`BPRED_BTB_ENTRIES];
    logic [AW-1:0] target_q [`BPRED_BTB_ENTRIES];
    logic          jump_q   [`BPRED_BTB_ENTRIES];
    logic          branch_q [`BPRED_BTB_ENTRIES];
    logic          valid_q  [`BPRED_BTB_ENTRIES];

    logic          bypass;

    assign bypass = we_i && (wr_idx_i == rd_idx_i);

    // a write to the entry being looked up wins.
    always_comb begin
        if (bypass) begin
            hit_o       = (wr_tag_i == rd_tag_i);
            target_o    = wr_target_i;
            is_jump_o   = wr_is_jump_i;
            is_branch_o = wr_is_branch_i;
        end else begin
            hit_o       = valid_q[rd_idx_i] && (tag_q[rd_idx_i] == rd_tag_i);
            target_o    = target_q[rd_idx_i];
            is_jump_o   = jump_q[rd_idx_i];
            is_branch_o = branch_q[rd_idx_i];
        end
    end

    // payload arrays.
    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_q[wr_idx_i]    <= wr_tag_i;
            target_q[wr_idx_i] <= wr_target_i;
            jump_q[wr_idx_i]   <= wr_is_jump_i;
            branch_q[wr_idx_i] <= wr_is_branch_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `BPRED_BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0; // whole table invalid.
            end
        end else if (we_i) begin
            valid_q[wr_idx_i] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* bpred_lookup.sv */
// fetch stage, hashes the pc and turns the btb and pht reads into a prediction.
`timescale 1ns/1ps
`default_nettype none

`include "bpred_settings.svh"

module bpred_lookup (
    input  bpred_pkg::addr_t    pc_i,
    input  bpred_pkg::ghr_t     ghr_i,
    output bpred_pkg::btb_idx_t btb_idx_o,
    output bpred_pkg::ghr_t     pht_idx_o,
    input  logic                btb_hit_i,
    input  bpred_pkg::addr_t    btb_target_i,
    input  logic                btb_is_jump_i,
    input  logic                btb_is_branch_i,
    input  bpred_pkg::pht_ctr_t pht_ctr_i,
    output logic                pred_taken_o,
    output bpred_pkg::addr_t    pred_target_o
);

    import bpred_pkg::*;

    localparam int IDX_W = $bits(btb_idx_t);

    ghr_t pc_bits;
    logic branch_taken;

    // word index, halfword bits dropped.
    assign btb_idx_o = pc_i[IDX_W+1:2];
    assign pc_bits   = pc_i[`BPRED_GHR_BITS+1:2];
    assign pht_idx_o = pc_bits ^ ghr_i; // gshare hash.

    assign branch_taken = btb_is_branch_i && pht_ctr_i[1];

    // jumps on a hit always go.
    assign pred_taken_o  = btb_hit_i && (btb_is_jump_i || branch_taken);
    assign pred_target_o = btb_hit_i ? btb_target_i : '0;

endmodule

`default_nettype wire

/* bpred_pht.sv */
// gshare pattern history table and global history register.
`timescale 1ns/1ps
`default_nettype none

`include "bpred_settings.svh"

module bpred_pht (
    input  logic                clk,
    input  logic                reset_i,
    input  bpred_pkg::ghr_t     rd_idx_i,
    output bpred_pkg::pht_ctr_t rd_ctr_o,
    output bpred_pkg::ghr_t     ghr_o,
    input  logic                upd_i,
    input  bpred_pkg::ghr_t     upd_idx_i,
    input  logic                upd_taken_i,
    input  logic                ghr_clear_i
);

    import bpred_pkg::*;

    localparam int PHT_SIZE = 1 << `BPRED_GHR_BITS;

    pht_ctr_t ctr_q [PHT_SIZE];
    pht_ctr_t upd_ctr;
    ghr_t     ghr_q;

    // next value of the counter under update, saturating.
    always_comb begin
        upd_ctr = ctr_q[upd_idx_i];
        if (upd_taken_i && upd_ctr != 2'b11) begin
            upd_ctr = upd_ctr + 2'b01;
        end else if (!upd_taken_i && upd_ctr != 2'b00) begin
            upd_ctr = upd_ctr - 2'b01;
        end
    end

    assign rd_ctr_o = (upd_i && upd_idx_i == rd_idx_i) ? upd_ctr : ctr_q[rd_idx_i];
    assign ghr_o    = ghr_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < PHT_SIZE; i++) begin
                ctr_q[i] <= 2'b01; // weakly not taken.
            end
        end else if (upd_i) begin
            ctr_q[upd_idx_i] <= upd_ctr;
        end
    end

    // history only moves at resolution.
    always_ff @(posedge clk) begin
        if (reset_i || ghr_clear_i) begin
            ghr_q <= '0;
        end else if (upd_i) begin
            ghr_q <= {ghr_q[`BPRED_GHR_BITS-2:0], upd_taken_i};
        end
    end

endmodule

`default_nettype wire

/* bpred_pkg.sv */
// shared types for the fetch, decode and execute stages of the predictor.
`default_nettype none

`include "bpred_settings.svh"

package bpred_pkg;

    // instruction address, full width.
    typedef logic [31:0] addr_t;

    typedef logic [6:0] opcode_t;

    // btb index from pc bits above the halfword bits.
    typedef logic [$clog2(`BPRED_BTB_ENTRIES)-1:0] btb_idx_t;

    // global history, doubles as the pht index.
    typedef logic [`BPRED_GHR_BITS-1:0] ghr_t;

    // 2-bit saturating counter, msb is the prediction.
    typedef logic [1:0] pht_ctr_t;

endpackage

`default_nettype wire

/* bpred_resolve.sv */
// execute stage, checks the prediction against the outcome and forms table updates.
`timescale 1ns/1ps
`default_nettype none

`include "bpred_settings.svh"

module bpred_resolve (
    input  logic                e_valid_i,
    input  bpred_pkg::addr_t    e_pc_i,
    input  bpred_pkg::opcode_t  e_op_i,
    input  logic                e_taken_i,
    input  bpred_pkg::addr_t    e_target_i,
    input  bpred_pkg::ghr_t     e_pht_idx_i,
    input  logic                actual_taken_i,
    input  bpred_pkg::addr_t    actual_target_i,
    output logic                mispredict_o,
    output bpred_pkg::addr_t    redirect_pc_o,
    output logic                pht_upd_o,
    output bpred_pkg::ghr_t     pht_idx_o,
    output logic                pht_taken_o,
    output logic                btb_we_o,
    output bpred_pkg::btb_idx_t btb_idx_o,
    output bpred_pkg::addr_t    btb_target_o,
    output logic                btb_is_jump_o,
    output logic                btb_is_branch_o
);

    import bpred_pkg::*;

    localparam int IDX_W = $bits(btb_idx_t);

    logic is_branch;
    logic is_jump;
    logic dir_wrong;
    logic tgt_wrong;

    assign is_branch = (e_op_i == `BPRED_OP_BRANCH);
    assign is_jump   = (e_op_i == `BPRED_OP_JAL) || (e_op_i == `BPRED_OP_JALR);

    // wrong direction, or taken both ways but to a different place.
    assign dir_wrong = (actual_taken_i != e_taken_i);
    assign tgt_wrong = actual_taken_i && e_taken_i && (actual_target_i != e_target_i);

    assign mispredict_o  = e_valid_i && (dir_wrong || tgt_wrong);
    assign redirect_pc_o = actual_taken_i ? actual_target_i : e_pc_i + 32'd4;

    // counters and history learn from branches only.
    assign pht_upd_o   = e_valid_i && is_branch;
    assign pht_idx_o   = e_pht_idx_i;
    assign pht_taken_o = actual_taken_i;

    // allocate or refresh on a taken control transfer.
    assign btb_we_o        = e_valid_i && (is_jump || is_branch) && actual_taken_i;
    assign btb_idx_o       = e_pc_i[IDX_W+1:2];
    assign btb_target_o    = actual_target_i;
    assign btb_is_jump_o   = is_jump;
    assign btb_is_branch_o = is_branch;

endmodule

`default_nettype wire

/* bpred_settings.svh */
// branch predictor sizing and rv32i opcode constants.
`ifndef BPRED_SETTINGS_SVH
`define BPRED_SETTINGS_SVH

// direct-mapped btb, power of two.
`define BPRED_BTB_ENTRIES 32

// history length, also the pht index width.
`define BPRED_GHR_BITS 5

// conditional branches (beq, bne, blt, ...).
`define BPRED_OP_BRANCH 7'b1100011

// unconditional jumps.
`define BPRED_OP_JAL 7'b1101111
`define BPRED_OP_JALR 7'b1100111

`endif

/* bpred_tb.sv */
// random-stimulus testbench that checks the branch predictor against a reference model.
`timescale 1ns/1ps
`default_nettype none

`include "bpred_settings.svh"

module bpred_tb;

    import bpred_pkg::*;

    localparam int      NUM_CYCLES   = 2000;
    localparam int      RESET_CYCLES = 16;
    localparam real     CLK_PERIOD   = 4.0;
    localparam int      NUM_PCS      = 12;
    localparam int      BTB_N        = `BPRED_BTB_ENTRIES;
    localparam int      PHT_N        = 1 << `BPRED_GHR_BITS;
    localparam opcode_t OP_ALU       = 7'b0110011;

    logic    clk;
    logic    reset_i;
    addr_t   pc_i;
    opcode_t op_i;
    logic    ghr_clear_i;
    logic    actual_taken_i;
    addr_t   actual_target_i;
    logic    pred_taken_o;
    addr_t   pred_target_o;
    logic    mispredict_o;
    addr_t   redirect_pc_o;

    // small pc pool so btb and pht entries alias.
    addr_t   pool_pc     [NUM_PCS];
    opcode_t pool_op     [NUM_PCS];
    addr_t   pool_target [NUM_PCS];
    int      pool_bias   [NUM_PCS]; // percent taken.

    // reference tables.
    logic     btb_valid  [BTB_N];
    addr_t    btb_tag    [BTB_N];
    addr_t    btb_target [BTB_N];
    logic     btb_jump   [BTB_N];
    logic     btb_branch [BTB_N];
    pht_ctr_t ctr        [PHT_N];
    ghr_t     ghr;

    // decode and execute slots with their pool index.
    logic  d_valid;
    logic  e_valid;
    int    f_slot;
    int    d_slot;
    int    e_slot;
    logic  d_taken;
    logic  e_taken;
    addr_t d_target;
    addr_t e_target;
    ghr_t  d_idx;
    ghr_t  e_idx;

    // values worked out for the current cycle.
    logic     exp_mis;
    addr_t    exp_redirect;
    logic     exp_taken;
    addr_t    exp_target;
    ghr_t     f_idx;
    logic     upd_pht;
    pht_ctr_t upd_ctr;
    logic     upd_btb;

    int          num_checks;
    int          num_mispredicts;
    int          num_hits;

    bpred_top bpred_top_inst (
        .clk(clk), .reset_i(reset_i), .pc_i(pc_i), .op_i(op_i), .ghr_clear_i(ghr_clear_i),
        .actual_taken_i(actual_taken_i), .actual_target_i(actual_target_i),
        .pred_taken_o(pred_taken_o), .pred_target_o(pred_target_o),
        .mispredict_o(mispredict_o), .redirect_pc_o(redirect_pc_o)
    );

    function automatic int btb_index(input addr_t pc);
        return int'((pc >> 2) % BTB_N);
    endfunction

    function automatic ghr_t pht_bits(input addr_t pc);
        return ghr_t'((pc >> 2) % PHT_N);
    endfunction

    function automatic pht_ctr_t sat_next(input pht_ctr_t c, input logic taken);
        if (taken) begin
            return (c == 2'b11) ? c : c + 2'b01;
        end
        return (c == 2'b00) ? c : c - 2'b01;
    endfunction

    function automatic addr_t random_target();
        return 32'h0000_2000 + (addr_t'($urandom_range(0, 1023)) << 2);
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        num_checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0.1f ns: %s is %h, expected %h", $realtime, what, got, exp);
            $display("sim failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic build_pool();
        int r;
        for (int i = 0; i < NUM_PCS; i++) begin
            r = $urandom_range(0, 99);
            pool_pc[i]     = 32'h0000_1000 + (addr_t'($urandom_range(0, 63)) << 2);
            pool_target[i] = random_target();
            pool_op[i]     = (r < 40) ? `BPRED_OP_BRANCH :
                             (r < 50) ? `BPRED_OP_JAL :
                             (r < 60) ? `BPRED_OP_JALR : OP_ALU;
            case ($urandom_range(0, 2))
                0: pool_bias[i] = 10;
                1: pool_bias[i] = 50;
                default: pool_bias[i] = 90;
            endcase
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < BTB_N; i++) begin
            btb_valid[i]  = 1'b0;
            btb_tag[i]    = '0;
            btb_target[i] = '0;
            btb_jump[i]   = 1'b0;
            btb_branch[i] = 1'b0;
        end
        for (int i = 0; i < PHT_N; i++) begin
            ctr[i] = 2'b01;
        end
        ghr      = '0;
        d_valid  = 1'b0;
        e_valid  = 1'b0;
        d_slot   = 0;
        e_slot   = 0;
        d_taken  = 1'b0;
        e_taken  = 1'b0;
        d_target = '0;
        e_target = '0;
        d_idx    = '0;
        e_idx    = '0;
    endtask

    task automatic drive_inputs();
        f_slot          = $urandom_range(0, NUM_PCS - 1);
        pc_i            = pool_pc[f_slot];
        op_i            = pool_op[d_slot];
        ghr_clear_i     = ($urandom_range(0, 99) < 2);
        actual_target_i = pool_target[e_slot];
        case (pool_op[e_slot])
            `BPRED_OP_BRANCH: actual_taken_i = ($urandom_range(0, 99) < pool_bias[e_slot]);
            `BPRED_OP_JAL: actual_taken_i = 1'b1;
            `BPRED_OP_JALR: begin
                if ($urandom_range(0, 99) < 10) begin
                    pool_target[e_slot] = random_target(); // indirect target moves.
                end
                actual_target_i = pool_target[e_slot];
                actual_taken_i  = 1'b1;
            end
            default: begin
                actual_taken_i  = 1'b0;
                actual_target_i = '0;
            end
        endcase
    endtask

    task automatic predict_and_check();
        addr_t e_pc;
        logic  is_branch;
        logic  is_jump;
        int    wr_idx;
        int    rd_idx;
        logic  hit;
        addr_t tgt;
        logic  jump;
        logic  branch;
        e_pc      = pool_pc[e_slot];
        is_branch = (pool_op[e_slot] == `BPRED_OP_BRANCH);
        is_jump   = (pool_op[e_slot] == `BPRED_OP_JAL) || (pool_op[e_slot] == `BPRED_OP_JALR);

        exp_mis = e_valid && ((actual_taken_i != e_taken) ||
                              (actual_taken_i && e_taken && actual_target_i != e_target));
        exp_redirect = actual_taken_i ? actual_target_i : e_pc + 32'd4;
        upd_pht = e_valid && is_branch;
        upd_ctr = sat_next(ctr[e_idx], actual_taken_i);
        upd_btb = e_valid && (is_branch || is_jump) && actual_taken_i;
        wr_idx  = btb_index(e_pc);

        // fetch sees writes of the resolving instruction.
        rd_idx = btb_index(pc_i);
        f_idx  = pht_bits(pc_i) ^ ghr;
        if (upd_btb && wr_idx == rd_idx) begin
            hit    = (e_pc == pc_i);
            tgt    = actual_target_i;
            jump   = is_jump;
            branch = is_branch;
        end else begin
            hit    = btb_valid[rd_idx] && (btb_tag[rd_idx] == pc_i);
            tgt    = btb_target[rd_idx];
            jump   = btb_jump[rd_idx];
            branch = btb_branch[rd_idx];
        end
        exp_taken = hit && (jump || (branch &&
                    ((upd_pht && e_idx == f_idx) ? upd_ctr[1] : ctr[f_idx][1])));
        exp_target = hit ? tgt : '0;
        num_hits        += hit;
        num_mispredicts += exp_mis;

        check_value("pred_taken_o", pred_taken_o, exp_taken);
        check_value("pred_target_o", pred_target_o, exp_target);
        check_value("mispredict_o", mispredict_o, exp_mis);
        if (e_valid) begin
            check_value("redirect_pc_o", redirect_pc_o, exp_redirect);
        end
    endtask

    // what the clock edge at the end of the cycle does.
    task automatic advance_model();
        int wr_idx;
        wr_idx = btb_index(pool_pc[e_slot]);
        if (upd_btb) begin
            btb_valid[wr_idx]  = 1'b1;
            btb_tag[wr_idx]    = pool_pc[e_slot];
            btb_target[wr_idx] = actual_target_i;
            btb_jump[wr_idx]   = (pool_op[e_slot] != `BPRED_OP_BRANCH);
            btb_branch[wr_idx] = (pool_op[e_slot] == `BPRED_OP_BRANCH);
        end
        if (upd_pht) begin
            ctr[e_idx] = upd_ctr;
        end
        if (ghr_clear_i) begin
            ghr = '0;
        end else if (upd_pht) begin
            ghr = {ghr[`BPRED_GHR_BITS-2:0], actual_taken_i};
        end
        e_slot   = d_slot;
        e_taken  = d_taken;
        e_target = d_target;
        e_idx    = d_idx;
        d_slot   = f_slot;
        d_taken  = exp_taken;
        d_target = exp_target;
        d_idx    = f_idx;
        if (exp_mis) begin
            d_valid = 1'b0; // both younger instructions dropped.
            e_valid = 1'b0;
        end else begin
            e_valid = d_valid;
            d_valid = 1'b1;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2.0) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + NUM_CYCLES + 50));
        $display("timeout: the run did not finish in the expected number of cycles");
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'h57a4_b865));
        reset_i         = 1'b1;
        pc_i            = '0;
        op_i            = OP_ALU;
        ghr_clear_i     = 1'b0;
        actual_taken_i  = 1'b0;
        actual_target_i = '0;
        num_checks      = 0;
        num_mispredicts = 0;
        num_hits        = 0;
        build_pool();
        reset_model();

        repeat (RESET_CYCLES - 1) @(posedge clk);
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge clk);
            #0.5;
            reset_i = 1'b0;
            drive_inputs();
            #2.5;
            predict_and_check();
            advance_model();
        end

        $display("%0d checks, %0d btb hits, %0d mispredicts",
                 num_checks, num_hits, num_mispredicts);
        if (num_hits > 0 && num_mispredicts > 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("stimulus never produced a btb hit or a mispredict");
            $display("sim failed");
            $fatal(1, "coverage too low");
        end
    end

endmodule

`default_nettype wire

/* bpred_top.sv */
// branch predictor top, fetch lookup, tables, tracking pipeline and resolve.
`timescale 1ns/1ps
`default_nettype none

`include "bpred_settings.svh"

module bpred_top (
    input  logic               clk,
    input  logic               reset_i,
    input  bpred_pkg::addr_t   pc_i,
    input  bpred_pkg::opcode_t op_i,
    input  logic               ghr_clear_i,
    input  logic               actual_taken_i,
    input  bpred_pkg::addr_t   actual_target_i,
    output logic               pred_taken_o,
    output bpred_pkg::addr_t   pred_target_o,
    output logic               mispredict_o,
    output bpred_pkg::addr_t   redirect_pc_o
);

    import bpred_pkg::*;

    // fetch side.
    btb_idx_t btb_rd_idx;
    ghr_t     pht_rd_idx;
    ghr_t     ghr;
    logic     btb_hit;
    addr_t    btb_target;
    logic     btb_is_jump;
    logic     btb_is_branch;
    pht_ctr_t pht_rd_ctr;

    // execute side.
    logic     e_valid;
    addr_t    e_pc;
    opcode_t  e_op;
    logic     e_taken;
    addr_t    e_target;
    ghr_t     e_pht_idx;
    logic     pht_upd;
    ghr_t     pht_upd_idx;
    logic     pht_upd_taken;
    logic     btb_we;
    btb_idx_t btb_wr_idx;
    addr_t    btb_wr_target;
    logic     btb_wr_is_jump;
    logic     btb_wr_is_branch;

    bpred_lookup bpred_lookup_inst (
        .pc_i(pc_i), .ghr_i(ghr), .btb_idx_o(btb_rd_idx), .pht_idx_o(pht_rd_idx),
        .btb_hit_i(btb_hit), .btb_target_i(btb_target), .btb_is_jump_i(btb_is_jump),
        .btb_is_branch_i(btb_is_branch), .pht_ctr_i(pht_rd_ctr),
        .pred_taken_o(pred_taken_o), .pred_target_o(pred_target_o)
    );

    bpred_btb bpred_btb_inst (
        .clk(clk), .reset_i(reset_i), .rd_idx_i(btb_rd_idx), .rd_tag_i(pc_i),
        .hit_o(btb_hit), .target_o(btb_target), .is_jump_o(btb_is_jump),
        .is_branch_o(btb_is_branch), .we_i(btb_we), .wr_idx_i(btb_wr_idx),
        .wr_tag_i(e_pc), .wr_target_i(btb_wr_target), .wr_is_jump_i(btb_wr_is_jump),
        .wr_is_branch_i(btb_wr_is_branch)
    );

    bpred_pht bpred_pht_inst (
        .clk(clk), .reset_i(reset_i), .rd_idx_i(pht_rd_idx), .rd_ctr_o(pht_rd_ctr),
        .ghr_o(ghr), .upd_i(pht_upd), .upd_idx_i(pht_upd_idx),
        .upd_taken_i(pht_upd_taken), .ghr_clear_i(ghr_clear_i)
    );

    bpred_track bpred_track_inst (
        .clk(clk), .reset_i(reset_i), .flush_i(mispredict_o), .f_pc_i(pc_i),
        .f_taken_i(pred_taken_o), .f_target_i(pred_target_o), .f_pht_idx_i(pht_rd_idx),
        .d_op_i(op_i), .e_valid_o(e_valid), .e_pc_o(e_pc), .e_op_o(e_op),
        .e_taken_o(e_taken), .e_target_o(e_target), .e_pht_idx_o(e_pht_idx)
    );

    bpred_resolve bpred_resolve_inst (
        .e_valid_i(e_valid), .e_pc_i(e_pc), .e_op_i(e_op), .e_taken_i(e_taken),
        .e_target_i(e_target), .e_pht_idx_i(e_pht_idx), .actual_taken_i(actual_taken_i),
        .actual_target_i(actual_target_i), .mispredict_o(mispredict_o),
        .redirect_pc_o(redirect_pc_o), .pht_upd_o(pht_upd), .pht_idx_o(pht_upd_idx),
        .pht_taken_o(pht_upd_taken), .btb_we_o(btb_we), .btb_idx_o(btb_wr_idx),
        .btb_target_o(btb_wr_target), .btb_is_jump_o(btb_wr_is_jump),
        .btb_is_branch_o(btb_wr_is_branch)
    );

endmodule

`default_nettype wire

/* bpred_track.sv */
// decode and execute registers that carry each prediction until it resolves.
`timescale 1ns/1ps
`default_nettype none

`include "bpred_settings.svh"

module bpred_track (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                flush_i,
    input  bpred_pkg::addr_t    f_pc_i,
    input  logic                f_taken_i,
    input  bpred_pkg::addr_t    f_target_i,
    input  bpred_pkg::ghr_t     f_pht_idx_i,
    input  bpred_pkg::opcode_t  d_op_i,
    output logic                e_valid_o,
    output bpred_pkg::addr_t    e_pc_o,
    output bpred_pkg::opcode_t  e_op_o,
    output logic                e_taken_o,
    output bpred_pkg::addr_t    e_target_o,
    output bpred_pkg::ghr_t     e_pht_idx_o
);

    import bpred_pkg::*;

    logic  d_valid_q;
    addr_t d_pc_q;
    logic  d_taken_q;
    addr_t d_target_q;
    ghr_t  d_pht_idx_q;

    // valid bits, both dropped on a mispredict.
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            d_valid_q <= 1'b0;
            e_valid_o <= 1'b0;
        end else begin
            d_valid_q <= 1'b1;
            e_valid_o <= d_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        d_pc_q      <= f_pc_i;
        d_taken_q   <= f_taken_i;
        d_target_q  <= f_target_i;
        d_pht_idx_q <= f_pht_idx_i;

        e_pc_o      <= d_pc_q;
        e_op_o      <= d_op_i; // opcode known only in decode.
        e_taken_o   <= d_taken_q;
        e_target_o  <= d_target_q;
        e_pht_idx_o <= d_pht_idx_q;
    end

endmodule

`default_nettype wire
